//--- rv_params.svh
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// data path width
`define XLEN 64

// memory map, the core starts fetching at the bottom of the data RAM
`define RAM_BASE 64'h0000_0000_8000_0000
`define MTVEC_RESET (`RAM_BASE + 64'h100)
`define DMEM_WORDS 256

// fetch register value after reset, opcode matches nothing
`define IR_RESET 32'h0000_0001

// machine external interrupt, msb marks an interrupt cause
`define MCAUSE_MEI 64'h8000_0000_0000_000b
`define MSTATUS_MIE 3
`define MSTATUS_MPIE 7

`endif

//--- rv_pkg.sv
`include "rv_params.svh"

package rv_pkg;

    // supported operations, anything else decodes to op_none
    typedef enum logic [3:0] {
        op_none,
        op_lui,
        op_auipc,
        op_ld,
        op_sd,
        op_addi,
        op_add,
        op_sub,
        op_slt,
        op_jal,
        op_jalr,
        op_beq,
        op_mret
    } op_t;

    // decoded instruction handed from decode to execute
    typedef struct packed {
        op_t              op;
        logic [4:0]       rd;
        logic [4:0]       rs1;
        logic [4:0]       rs2;
        // already selected and sign extended for the op
        logic [`XLEN-1:0] imm;
        // op writes rd and rd is not x0
        logic             wb;
    } decoded_t;

    // data memory bus, registered in the core
    typedef struct packed {
        logic [`XLEN-1:0] address;
        logic [`XLEN-1:0] write_data;
        logic             write_enable;
        logic             read_enable;
        logic [`XLEN-1:0] read_address;
    } store_bus_t;

    // trap events from execute to the csr block
    typedef struct packed {
        logic             take_irq;
        logic             do_mret;
        // address of the instruction dropped by the interrupt
        logic [`XLEN-1:0] epc;
    } trap_ctl_t;

endpackage

//--- rv_decode.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_decode
    import rv_pkg::*;
(
    input  logic [31:0] ir,
    output decoded_t    dec
);

    // opcode and function fields
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    // immediates of every format
    logic [`XLEN-1:0] imm_u;
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_s;
    logic [`XLEN-1:0] imm_j;
    logic [`XLEN-1:0] imm_b;

    op_t op;

    assign opcode = ir[6:0];
    assign funct3 = ir[14:12];
    assign funct7 = ir[31:25];

    // u type for lui and auipc
    assign imm_u = {{32{ir[31]}}, ir[31:12], 12'b0};
    // i type for ld, addi and jalr
    assign imm_i = {{52{ir[31]}}, ir[31:20]};
    // s type splits the offset around rd
    assign imm_s = {{52{ir[31]}}, ir[31:25], ir[11:7]};
    // j and b types carry an implied zero lsb
    assign imm_j = {{44{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};
    assign imm_b = {{52{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};

    // operation match
    always_comb begin
        op = op_none;
        case (opcode)
            7'b0110111: op = op_lui;
            7'b0010111: op = op_auipc;
            7'b0000011: if (funct3 == 3'b011) op = op_ld;
            7'b0100011: if (funct3 == 3'b011) op = op_sd;
            7'b0010011: if (funct3 == 3'b000) op = op_addi;
            7'b0110011: begin
                if (funct3 == 3'b000 && funct7 == 7'b0000000) op = op_add;
                if (funct3 == 3'b000 && funct7 == 7'b0100000) op = op_sub;
                if (funct3 == 3'b010 && funct7 == 7'b0000000) op = op_slt;
            end
            7'b1101111: op = op_jal;
            7'b1100111: if (funct3 == 3'b000) op = op_jalr;
            7'b1100011: if (funct3 == 3'b000) op = op_beq;
            // mret is one fixed word
            7'b1110011: if (ir == 32'h3020_0073) op = op_mret;
            default: op = op_none;
        endcase
    end

    always_comb begin
        dec.op  = op;
        dec.rd  = ir[11:7];
        dec.rs1 = ir[19:15];
        dec.rs2 = ir[24:20];
        // immediate for the matched op
        case (op)
            op_lui, op_auipc:        dec.imm = imm_u;
            op_ld, op_addi, op_jalr: dec.imm = imm_i;
            op_sd:                   dec.imm = imm_s;
            op_jal:                  dec.imm = imm_j;
            op_beq:                  dec.imm = imm_b;
            default:                 dec.imm = '0;
        endcase
        // rd writers unless rd is x0
        case (op)
            op_lui, op_auipc, op_ld, op_addi, op_add, op_sub, op_slt, op_jal, op_jalr:
                dec.wb = (ir[11:7] != 5'd0);
            default:
                dec.wb = 1'b0;
        endcase
    end

endmodule

//--- rv_regfile.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_regfile (
    input  logic             clk,
    input  logic             reset,
    input  logic [4:0]       rs1,
    input  logic [4:0]       rs2,
    output logic [`XLEN-1:0] rs1_data,
    output logic [`XLEN-1:0] rs2_data,
    input  logic             we,
    input  logic [4:0]       rd,
    input  logic [`XLEN-1:0] rd_data
);

    // x0 has storage but is never written or read
    logic [`XLEN-1:0] regs [32];

    // one write port, lands at the end of the execute cycle
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != 5'd0) begin
            regs[rd] <= rd_data;
        end
    end

    // asynchronous reads
    // x0 forced to zero
    always_comb begin
        rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
        rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];
    end

endmodule

//--- rv_csr.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_csr
    import rv_pkg::*;
(
    input  logic             clk,
    input  logic             reset,
    input  trap_ctl_t        trap,
    output logic             irq_enable,
    output logic [`XLEN-1:0] mtvec,
    output logic [`XLEN-1:0] mepc
);

    // machine status, only MIE and MPIE change
    logic [`XLEN-1:0] mstatus;
    // cause of the last trap
    logic [`XLEN-1:0] mcause;

    assign irq_enable = mstatus[`MSTATUS_MIE];

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            // interrupts enabled out of reset
            mstatus              <= '0;
            mstatus[`MSTATUS_MIE] <= 1'b1;
            mepc                 <= '0;
            mcause               <= '0;
            // no csr writes, vector stays at its reset value
            mtvec                <= `MTVEC_RESET;
        end else if (trap.take_irq) begin
            // interrupt entry
            // stack MIE into MPIE and mask further interrupts
            mepc                   <= trap.epc;
            mcause                 <= `MCAUSE_MEI;
            mstatus[`MSTATUS_MPIE] <= mstatus[`MSTATUS_MIE];
            mstatus[`MSTATUS_MIE]  <= 1'b0;
        end else if (trap.do_mret) begin
            // return, MIE back from the stack
            mstatus[`MSTATUS_MIE]  <= mstatus[`MSTATUS_MPIE];
            mstatus[`MSTATUS_MPIE] <= 1'b1;
        end
    end

endmodule

//--- rv_core.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_core
    import rv_pkg::*;
(
    input  logic             clk,
    input  logic             reset,
    input  logic [31:0]      instruction,
    output logic [`XLEN-1:0] pc,
    output logic             heartbeat,
    input  logic [3:0]       interrupt_vector,
    output logic             interrupt_ack,
    output store_bus_t       bus,
    input  logic [`XLEN-1:0] bus_read_data
);

    logic [31:0] ir;
    decoded_t    dec;
    // set after any redirect, flushes the next ir
    logic        bubble;
    // second pass of ld pending
    logic        load_step;

    logic [`XLEN-1:0] rs1_data;
    logic [`XLEN-1:0] rs2_data;
    logic             rf_we;
    logic [`XLEN-1:0] rf_wdata;

    logic             irq_enable;
    logic [`XLEN-1:0] mtvec;
    logic [`XLEN-1:0] mepc;
    trap_ctl_t        trap;

    // address of the instruction in ir, pc already moved on by 4
    logic [`XLEN-1:0] pc_exec;
    // rs1 + imm for ld, sd and jalr
    logic [`XLEN-1:0] eff_addr;
    logic             irq_take;
    logic             exec_valid;

    rv_decode u_decode (
        .ir  (ir),
        .dec (dec)
    );

    rv_regfile u_regfile (
        .clk      (clk),
        .reset    (reset),
        .rs1      (dec.rs1),
        .rs2      (dec.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .we       (rf_we),
        .rd       (dec.rd),
        .rd_data  (rf_wdata)
    );

    rv_csr u_csr (
        .clk        (clk),
        .reset      (reset),
        .trap       (trap),
        .irq_enable (irq_enable),
        .mtvec      (mtvec),
        .mepc       (mepc)
    );

    assign pc_exec  = pc - `XLEN'd4;
    assign eff_addr = rs1_data + dec.imm;

    // interrupt only on a real ir, never mid load or in a bubble
    assign irq_take   = !bubble && !load_step && irq_enable && (interrupt_vector == 4'd1);
    assign exec_valid = !bubble && !irq_take;

    assign trap.take_irq = irq_take;
    assign trap.do_mret  = exec_valid && (dec.op == op_mret);
    assign trap.epc      = pc_exec;

    // ld writes rd only on its second pass
    assign rf_we = exec_valid && dec.wb && (dec.op != op_ld || load_step);

    // write-back value
    always_comb begin
        case (dec.op)
            op_lui:           rf_wdata = dec.imm;
            op_auipc:         rf_wdata = pc_exec + dec.imm;
            op_ld:            rf_wdata = bus_read_data;
            op_addi:          rf_wdata = eff_addr;
            op_add:           rf_wdata = rs1_data + rs2_data;
            op_sub:           rf_wdata = rs1_data - rs2_data;
            op_slt:           rf_wdata = {{(`XLEN-1){1'b0}},
                                          $signed(rs1_data) < $signed(rs2_data)};
            // link is the return address, which pc already holds
            op_jal, op_jalr:  rf_wdata = pc;
            default:          rf_wdata = '0;
        endcase
    end

    // fetch register and heartbeat
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            ir        <= `IR_RESET;
            heartbeat <= 1'b0;
        end else begin
            ir        <= instruction;
            heartbeat <= ~heartbeat;
        end
    end

    // execute: pc, bubble, load step and bus
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc            <= `RAM_BASE;
            bubble        <= 1'b0;
            load_step     <= 1'b0;
            interrupt_ack <= 1'b0;
            bus           <= '{address: `RAM_BASE, write_data: '0, write_enable: 1'b0,
                               read_enable: 1'b0, read_address: `RAM_BASE};
        end else begin
            // enables and ack are single cycle strobes
            pc               <= pc + `XLEN'd4;
            interrupt_ack    <= 1'b0;
            bus.write_enable <= 1'b0;
            bus.read_enable  <= 1'b0;
            if (irq_take) begin
                pc            <= mtvec;
                bubble        <= 1'b1;
                interrupt_ack <= 1'b1;
            end else if (bubble) begin
                bubble <= 1'b0;
            end else begin
                case (dec.op)
                    op_ld: begin
                        if (!load_step) begin
                            // issue the read and refetch this ld
                            bus.read_enable  <= 1'b1;
                            bus.read_address <= eff_addr;
                            pc               <= pc_exec;
                            bubble           <= 1'b1;
                            load_step        <= 1'b1;
                        end else begin
                            load_step <= 1'b0;
                        end
                    end
                    op_sd: begin
                        bus.address      <= eff_addr;
                        bus.write_data   <= rs2_data;
                        bus.write_enable <= 1'b1;
                        // hold pc, the flushed word gets fetched again
                        pc               <= pc;
                        bubble           <= 1'b1;
                    end
                    op_jal: begin
                        pc     <= pc_exec + dec.imm;
                        bubble <= 1'b1;
                    end
                    op_jalr: begin
                        pc     <= {eff_addr[`XLEN-1:1], 1'b0};
                        bubble <= 1'b1;
                    end
                    op_beq: begin
                        if (rs1_data == rs2_data) begin
                            pc     <= pc_exec + dec.imm;
                            bubble <= 1'b1;
                        end
                    end
                    op_mret: begin
                        pc     <= mepc;
                        bubble <= 1'b1;
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

//--- rv_dmem.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_dmem
    import rv_pkg::*;
(
    input  logic             clk,
    input  store_bus_t       bus,
    output logic [`XLEN-1:0] read_data
);

    localparam int INDEX_W = $clog2(`DMEM_WORDS);

    logic [`XLEN-1:0] mem [`DMEM_WORDS];

    // byte offsets into the RAM window
    logic [`XLEN-1:0] write_offset;
    logic [`XLEN-1:0] read_offset;

    assign write_offset = bus.address - `RAM_BASE;
    assign read_offset  = bus.read_address - `RAM_BASE;

    // doubleword index, low three bits are the byte lane
    always_ff @(posedge clk) begin
        if (bus.write_enable) begin
            mem[write_offset[INDEX_W+2:3]] <= bus.write_data;
        end
        // read data holds until the next read
        if (bus.read_enable) begin
            read_data <= mem[read_offset[INDEX_W+2:3]];
        end
    end

endmodule

//--- rv_soc.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_soc
    import rv_pkg::*;
(
    input  logic             clk,
    input  logic             reset,
    input  logic [31:0]      instruction,
    output logic [`XLEN-1:0] pc,
    output logic             heartbeat,
    input  logic [3:0]       interrupt_vector,
    output logic             interrupt_ack,
    output logic [`XLEN-1:0] bus_address,
    output logic [`XLEN-1:0] bus_write_data,
    output logic             bus_write_enable
);

    // core to RAM bus
    store_bus_t       bus;
    logic [`XLEN-1:0] bus_read_data;

    // instruction memory sits outside, core drives pc and takes the word back
    rv_core u_core (
        .clk              (clk),
        .reset            (reset),
        .instruction      (instruction),
        .pc               (pc),
        .heartbeat        (heartbeat),
        .interrupt_vector (interrupt_vector),
        .interrupt_ack    (interrupt_ack),
        .bus              (bus),
        .bus_read_data    (bus_read_data)
    );

    rv_dmem u_dmem (
        .clk       (clk),
        .bus       (bus),
        .read_data (bus_read_data)
    );

    // store side of the bus made visible at the top
    assign bus_address      = bus.address;
    assign bus_write_data   = bus.write_data;
    assign bus_write_enable = bus.write_enable;

endmodule

//--- tb_rv_soc.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module tb_rv_soc;

    // program words plus handler with margin for loads and redirects
    localparam int PROG_WORDS      = 51;
    localparam int WATCHDOG_CYCLES = 16 + PROG_WORDS * 4 + 100;
    // handler marker address which also ends the interrupt request
    localparam logic [63:0] HANDLER_STORE = `RAM_BASE + 64'h260;

    logic        clk;
    logic        reset;
    logic [31:0] instruction;
    logic [63:0] pc;
    logic        heartbeat;
    logic [3:0]  interrupt_vector;
    logic        interrupt_ack;
    logic [63:0] bus_address;
    logic [63:0] bus_write_data;
    logic        bus_write_enable;

    // instruction words from RAM_BASE with the handler at word 64
    logic [31:0] imem [128];
    // expected register file and data RAM contents
    logic [63:0] model [32];
    logic [63:0] ram_model [256];
    // store sequence the bus must show in order
    logic [63:0] exp_addr [$];
    logic [63:0] exp_data [$];

    int          wp;
    int          seed;
    int          pick;
    int          ack_count;
    logic [63:0] irq_pc;
    logic        irq_raised;
    logic        hb_prev;
    logic        hb_seen;

    rv_soc UUT (
        .clk              (clk),
        .reset            (reset),
        .instruction      (instruction),
        .pc               (pc),
        .heartbeat        (heartbeat),
        .interrupt_vector (interrupt_vector),
        .interrupt_ack    (interrupt_ack),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_write_enable (bus_write_enable)
    );

    always #10 clk = ~clk;

    task automatic report_mismatch(string name, logic [63:0] expected, logic [63:0] actual);
        $display("[ERROR] %s expected 0x%h actual 0x%h", name, expected, actual);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic report_failure(string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    // instruction formats
    function automatic logic [31:0] r_type(int f7, int rs2, int rs1, int f3, int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(int imm, int rs1, int f3, int rd, int opc);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
    endfunction

    function automatic logic [31:0] s_type(int imm, int rs2, int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b011, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] b_type(int off, int rs2, int rs1);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], 3'b000, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] u_type(int imm, int rd, int opc);
        return {imm[19:0], rd[4:0], opc[6:0]};
    endfunction

    function automatic logic [31:0] j_type(int off, int rd);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
    endfunction

    // address of the word being assembled
    function automatic logic [63:0] here();
        return `RAM_BASE + 64'(4 * wp);
    endfunction

    task automatic emit(logic [31:0] word);
        imem[wp[6:0]] = word;
        wp++;
    endtask

    task automatic write_reg(int rd, logic [63:0] value);
        if (rd != 0)
            model[rd[4:0]] = value;
    endtask

    // mnemonics that update the model then place their word
    task automatic lui(int rd, int imm);
        int     w;
        longint v;
        w = imm << 12;
        v = w;
        write_reg(rd, v);
        emit(u_type(imm, rd, 7'b0110111));
    endtask

    task automatic auipc(int rd, int imm);
        int     w;
        longint v;
        w = imm << 12;
        v = w;
        write_reg(rd, here() + v);
        emit(u_type(imm, rd, 7'b0010111));
    endtask

    task automatic addi(int rd, int rs1, int imm);
        longint simm;
        simm = imm;
        write_reg(rd, model[rs1[4:0]] + simm);
        emit(i_type(imm, rs1, 0, rd, 7'b0010011));
    endtask

    task automatic add(int rd, int rs1, int rs2);
        write_reg(rd, model[rs1[4:0]] + model[rs2[4:0]]);
        emit(r_type(7'b0000000, rs2, rs1, 0, rd));
    endtask

    task automatic sub(int rd, int rs1, int rs2);
        write_reg(rd, model[rs1[4:0]] - model[rs2[4:0]]);
        emit(r_type(7'b0100000, rs2, rs1, 0, rd));
    endtask

    task automatic slt(int rd, int rs1, int rs2);
        // signed compare
        if ($signed(model[rs1[4:0]]) < $signed(model[rs2[4:0]]))
            write_reg(rd, 64'd1);
        else
            write_reg(rd, 64'd0);
        emit(r_type(7'b0000000, rs2, rs1, 2, rd));
    endtask

    task automatic ld(int rd, int rs1, int imm);
        longint      simm;
        logic [63:0] off;
        simm = imm;
        off = model[rs1[4:0]] + simm - `RAM_BASE;
        write_reg(rd, ram_model[off[10:3]]);
        emit(i_type(imm, rs1, 3, rd, 7'b0000011));
    endtask

    // sd rs2, imm(rs1)
    task automatic sd(int rs2, int rs1, int imm);
        longint      simm;
        logic [63:0] addr;
        logic [63:0] off;
        simm = imm;
        addr = model[rs1[4:0]] + simm;
        off = addr - `RAM_BASE;
        ram_model[off[10:3]] = model[rs2[4:0]];
        exp_addr.push_back(addr);
        exp_data.push_back(model[rs2[4:0]]);
        emit(s_type(imm, rs2, rs1));
    endtask

    // store on a path that must never execute
    task automatic skipped_store();
        emit(s_type(12'h3f0, 2, 1));
    endtask

    task automatic beq(int rs1, int rs2, int off);
        emit(b_type(off, rs2, rs1));
    endtask

    task automatic jal(int rd, int off);
        write_reg(rd, here() + 64'd4);
        emit(j_type(off, rd));
    endtask

    task automatic jalr(int rd, int rs1, int imm);
        write_reg(rd, here() + 64'd4);
        emit(i_type(imm, rs1, 0, rd, 7'b1100111));
    endtask

    function automatic logic [31:0] fetch_word(logic [63:0] addr);
        logic [63:0] off;
        off = addr - `RAM_BASE;
        if (off < 64'd512)
            return imem[off[8:2]];
        return 32'h0000_0013;
    endfunction

    // instruction and interrupt request follow the pc just after each edge
    always @(posedge clk) begin
        #2;
        instruction <= fetch_word(pc);
        if (!irq_raised && pc == irq_pc) begin
            interrupt_vector <= 4'd1;
            irq_raised = 1'b1;
        end else if (bus_write_enable && bus_address == HANDLER_STORE) begin
            // held through the handler entry, dropped before mret
            interrupt_vector <= 4'd0;
        end
    end

    // stores compared mid cycle against the model sequence
    always @(negedge clk) begin
        if (reset && bus_write_enable) begin
            if (exp_addr.size() == 0) begin
                report_failure("store strobe seen after the last expected store");
            end else begin
                assert (bus_address == exp_addr[0])
                    else report_mismatch("bus_address", exp_addr[0], bus_address);
                assert (bus_write_data == exp_data[0])
                    else report_mismatch("bus_write_data", exp_data[0], bus_write_data);
                void'(exp_addr.pop_front());
                void'(exp_data.pop_front());
            end
        end
        if (reset && interrupt_ack) begin
            ack_count++;
            assert (ack_count == 1)
                else report_failure("a second interrupt_ack came while MIE was clear");
        end
        // heartbeat flips every cycle once out of reset
        if (reset) begin
            if (hb_seen) begin
                assert (heartbeat != hb_prev)
                    else report_mismatch("heartbeat", 64'(!hb_prev), 64'(heartbeat));
            end
            hb_prev = heartbeat;
            hb_seen = 1'b1;
        end
    end

    // ack is a single pulse and the fetch goes straight to the vector
    ack_pulse: assert property (@(posedge clk) disable iff (!reset)
        interrupt_ack |=> !interrupt_ack)
        else report_failure("interrupt_ack stayed high for more than one cycle");

    ack_vector: assert property (@(posedge clk) disable iff (!reset)
        interrupt_ack |-> pc == `MTVEC_RESET)
        else report_mismatch("pc", `MTVEC_RESET, $sampled(pc));

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        report_failure("watchdog expired before the store sequence completed");
    end

    initial begin
        clk = 1'b0;
        reset = 1'b0;
        instruction = 32'h0000_0013;
        interrupt_vector = 4'd0;
        irq_raised = 1'b0;
        hb_seen = 1'b0;
        hb_prev = 1'b0;
        ack_count = 0;
        for (int i = 0; i < 32; i++)
            model[i] = '0;
        for (int i = 0; i < 256; i++)
            ram_model[i] = '0;
        // addi x0, x0, index as filler
        for (int i = 0; i < 128; i++)
            imem[i] = i_type(i, 0, 0, 0, 7'b0010011);

        wp = 0;
        // x1 holds RAM_BASE for every store
        auipc(1, 0);
        lui(2, 'h12345);
        addi(2, 2, 'h678);
        sd(2, 1, 'h200);
        sd(1, 1, 'h208);
        addi(3, 0, -5);
        addi(4, 0, 7);
        add(5, 3, 4);
        sub(6, 3, 4);
        slt(7, 3, 4);
        slt(8, 4, 3);
        sd(5, 1, 'h210);
        sd(6, 1, 'h218);
        sd(7, 1, 'h220);
        sd(8, 1, 'h228);
        // round trip through the RAM
        ld(9, 1, 'h218);
        sd(9, 1, 'h230);
        // x0 stays zero
        addi(0, 0, 55);
        add(0, 2, 2);
        sd(0, 1, 'h238);
        // taken beq over a marker, then a not taken beq
        beq(3, 3, 8);
        skipped_store();
        beq(3, 4, 8);
        addi(10, 0, 100);
        jal(11, 12);
        skipped_store();
        skipped_store();
        sd(11, 1, 'h240);
        auipc(12, 0);
        jalr(13, 12, 16);
        skipped_store();
        skipped_store();
        sd(10, 1, 'h248);
        sd(13, 1, 'h250);
        // plain ALU window of words 34 to 45 where the interrupt lands
        for (int k = 1; k <= 12; k++)
            addi(14, 14, k);
        // handler at the trap vector whose store comes before the window sum
        pick = wp;
        wp = 64;
        addi(31, 0, 'h7ab);
        sd(31, 1, 'h260);
        emit(32'h3020_0073);
        wp = pick;
        sd(14, 1, 'h258);
        jal(0, 0);

        // request shows while one of words 34 to 43 sits in ir
        seed = 85180;
        pick = $random(seed) % 10;
        if (pick < 0)
            pick = -pick;
        irq_pc = `RAM_BASE + 64'(4 * (35 + pick));

        repeat (15) begin
            @(negedge clk);
            assert (pc == `RAM_BASE) else report_mismatch("pc", `RAM_BASE, pc);
            assert (!bus_write_enable) else report_failure("bus_write_enable high in reset");
            assert (!interrupt_ack) else report_failure("interrupt_ack high in reset");
        end
        @(posedge clk);
        #2;
        reset = 1'b1;
        @(negedge clk);
        assert (pc == `RAM_BASE) else report_mismatch("pc", `RAM_BASE, pc);

        while (exp_addr.size() != 0)
            @(posedge clk);
        // idle loop at the end must stay quiet
        repeat (20) @(posedge clk);
        if (ack_count == 1) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            report_failure("the interrupt was never acknowledged");
        end
    end

endmodule

//--- build.f
+incdir+.
rv_pkg.sv
rv_decode.sv
rv_regfile.sv
rv_csr.sv
rv_core.sv
rv_dmem.sv
rv_soc.sv
tb_rv_soc.sv

//--- Makefile
# Verilator flow for the rv_soc testbench

TOP = tb_rv_soc

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) \
		-Mdir obj_dir -o $(TOP)

# the log decides, the simulator exit status is not trusted alone
run: compile
	./obj_dir/$(TOP) | tee sim.log
	grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
